// ==== source/debugPort_defines.svh ====
`ifndef DEBUGPORT_DEFINES_SVH
`define DEBUGPORT_DEFINES_SVH

// data, register, pc and memory word width
`define DEBUG_DATA_WIDTH 16

// debug address and memory address width
`define DEBUG_ADDR_WIDTH 8

// core register file size
`define DEBUG_REG_COUNT 8

// memory words, one per address
`define DEBUG_MEM_DEPTH 256

`endif

// ==== source/debugPkg.sv ====
`default_nettype none

package debugPkg;

	// command field, opcode bits 3 to 1; value 7 is undefined
	typedef enum logic [2:0] {
		opNone          = 3'd0,
		opRdReg         = 3'd1,
		opRdCc          = 3'd2,
		opRdPc          = 3'd3,
		opRdInstruction = 3'd4,
		opRdMem         = 3'd5,
		opWrMem         = 3'd6
	} debugOpT;

	typedef enum logic [2:0] {
		dataDin         = 3'd0, // memory read data
		dataRegB        = 3'd1,
		dataCc          = 3'd2,
		dataPc          = 3'd3,
		dataInstruction = 3'd4
	} dataSelT;

	typedef enum logic [1:0] {
		busNone  = 2'd0,
		busRead  = 2'd1,
		busWrite = 2'd2
	} busSeqT;

	typedef enum logic [3:0] {
		regSeqNone  = 4'd0,
		regSeqReadB = 4'd1
	} regSeqT;

	typedef enum logic [1:0] {
		ccRun   = 2'd0,
		ccIntr  = 2'd1,
		ccSave1 = 2'd2,
		ccSave2 = 2'd3
	} ccSelT;

	typedef enum logic [2:0] {
		addrBusDebug = 3'd0,
		addrBusPc    = 3'd1
	} addrBusSelT;

endpackage

`default_nettype wire

// ==== source/debugDecoder.sv ====
`default_nettype none

module debugDecoder import debugPkg::*; (
	input  debugOpT    op,
	input  logic       autoInc,
	input  logic [2:0] arg,
	output dataSelT    dataSel,
	output busSeqT     busSeq,
	output regSeqT     regSeq,
	output ccSelT      ccSel,
	output addrBusSelT addrBusSel,
	output logic       ldData,
	output logic       ldArg,
	output logic       addrInc
);

	always_comb begin
		case (op)
			opRdReg: begin
				dataSel    = dataRegB;
				busSeq     = busNone;
				regSeq     = regSeqReadB;
				ccSel      = ccRun;
				addrBusSel = addrBusDebug;
				ldData     = 1'b1;
				ldArg      = 1'b0;
				addrInc    = autoInc;
			end
			opRdCc: begin
				dataSel    = dataCc;
				busSeq     = busNone;
				regSeq     = regSeqNone;
				ccSel      = ccSelT'(arg[1:0]); // arg picks the saved word
				addrBusSel = addrBusDebug;
				ldData     = 1'b1;
				ldArg      = 1'b0;
				addrInc    = 1'b0;
			end
			opRdPc: begin
				dataSel    = dataPc;
				busSeq     = busNone;
				regSeq     = regSeqNone;
				ccSel      = ccRun;
				addrBusSel = addrBusPc;
				ldData     = 1'b1;
				ldArg      = 1'b0;
				addrInc    = 1'b0;
			end
			opRdInstruction: begin
				dataSel    = dataInstruction;
				busSeq     = busRead; // fetch at pc
				regSeq     = regSeqNone;
				ccSel      = ccRun;
				addrBusSel = addrBusPc;
				ldData     = 1'b1;
				ldArg      = 1'b1;
				addrInc    = 1'b0;
			end
			opRdMem: begin
				dataSel    = dataDin;
				busSeq     = busRead;
				regSeq     = regSeqNone;
				ccSel      = ccRun;
				addrBusSel = addrBusDebug;
				ldData     = 1'b1;
				ldArg      = 1'b0;
				addrInc    = autoInc;
			end
			opWrMem: begin
				dataSel    = dataDin;
				busSeq     = busWrite;
				regSeq     = regSeqNone;
				ccSel      = ccRun;
				addrBusSel = addrBusDebug;
				ldData     = 1'b0;
				ldArg      = 1'b0;
				addrInc    = autoInc;
			end
			default: begin // opNone and the undefined code
				dataSel    = dataDin;
				busSeq     = busNone;
				regSeq     = regSeqNone;
				ccSel      = ccRun;
				addrBusSel = addrBusDebug;
				ldData     = 1'b0;
				ldArg      = 1'b0;
				addrInc    = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/debugSequencer.sv ====
`default_nettype none

module debugSequencer import debugPkg::*; (
	input  logic       CLK,
	input  logic       arstN,
	input  logic       debugStrobe,
	input  logic [4:0] debugOp,
	input  logic [2:0] debugArg,
	input  busSeqT     busSeq,
	output debugOpT    op,
	output logic       autoInc,
	output logic [2:0] arg,
	output logic       memRead,
	output logic       memWrite,
	output logic       execute,
	output logic       debugBusy,
	output logic       debugDone
);

	typedef enum logic [1:0] {
		stIdle,
		stIssue,
		stWaitRead,
		stFinish
	} seqStateT;

	seqStateT state;
	logic accept;

	// done cycle can take the next command
	assign accept = debugStrobe && (state == stIdle || state == stFinish);

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state   <= stIdle;
			op      <= opNone;
			autoInc <= 1'b0;
			arg     <= 3'd0;
		end else begin
			if (accept) begin
				op      <= debugOpT'(debugOp[3:1]); // bit 4 reserved
				autoInc <= debugOp[0];
				arg     <= debugArg;
			end
			case (state)
				stIdle:     state <= accept ? stIssue : stIdle;
				stIssue:    state <= (busSeq == busRead) ? stWaitRead : stFinish;
				stWaitRead: state <= stFinish;
				stFinish:   state <= accept ? stIssue : stIdle;
				default:    state <= stIdle;
			endcase
		end
	end

	assign memRead   = (state == stIssue) && (busSeq == busRead);
	assign memWrite  = (state == stIssue) && (busSeq == busWrite);

	// reads wait one cycle for ram data
	assign execute   = (state == stWaitRead) || (state == stIssue && busSeq != busRead);
	assign debugBusy = (state == stIssue) || (state == stWaitRead);
	assign debugDone = (state == stFinish);

endmodule

`default_nettype wire

// ==== source/debugDatapath.sv ====
`default_nettype none
`include "debugPort_defines.svh"

module debugDatapath import debugPkg::*; #(
	parameter int REG_BITS = $clog2(`DEBUG_REG_COUNT)
) (
	input  logic                         CLK,
	input  logic                         arstN,
	input  logic                         execute,
	input  logic                         debugAddrLoad,
	input  logic                         debugBusy,
	input  logic [`DEBUG_DATA_WIDTH-1:0] debugDin,
	input  dataSelT                      dataSel,
	input  logic                         ldData,
	input  logic                         ldArg,
	input  logic                         addrInc,
	input  addrBusSelT                   addrBusSel,
	input  logic [`DEBUG_DATA_WIDTH-1:0] regB,
	input  logic [`DEBUG_DATA_WIDTH-1:0] ccWord,
	input  logic [`DEBUG_DATA_WIDTH-1:0] pc,
	input  logic [`DEBUG_DATA_WIDTH-1:0] memRData,
	output logic [`DEBUG_ADDR_WIDTH-1:0] memAddr,
	output logic [`DEBUG_DATA_WIDTH-1:0] memWData,
	output logic [REG_BITS-1:0]          regIndex,
	output logic [`DEBUG_DATA_WIDTH-1:0] debugDout,
	output logic [`DEBUG_DATA_WIDTH-1:0] debugInstr
);

	logic [`DEBUG_ADDR_WIDTH-1:0] debugAddr;
	logic [`DEBUG_DATA_WIDTH-1:0] dinHold;
	logic [`DEBUG_DATA_WIDTH-1:0] dataMux;

	// keeps the strobe cycle's word for the write at E1
	always_ff @(posedge CLK) begin
		if (!debugBusy)
			dinHold <= debugDin;
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			debugAddr <= '0;
		end else if (debugAddrLoad && !debugBusy) begin
			debugAddr <= debugDin[`DEBUG_ADDR_WIDTH-1:0];
		end else if (execute && addrInc) begin
			debugAddr <= debugAddr + 1'b1; // wraps 255 to 0
		end
	end

	always_comb begin
		case (dataSel)
			dataRegB:        dataMux = regB;
			dataCc:          dataMux = ccWord;
			dataPc:          dataMux = pc;
			default:         dataMux = memRData; // memory word, also the one the ir takes
		endcase
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			debugDout  <= '0;
			debugInstr <= '0;
		end else if (execute) begin
			if (ldData)
				debugDout <= dataMux;
			if (ldArg)
				debugInstr <= memRData;
		end
	end

	assign memAddr  = (addrBusSel == addrBusPc) ? pc[`DEBUG_ADDR_WIDTH-1:0] : debugAddr;
	assign memWData = dinHold;
	assign regIndex = debugAddr[REG_BITS-1:0];

endmodule

`default_nettype wire

// ==== source/coreStateFile.sv ====
`default_nettype none
`include "debugPort_defines.svh"

module coreStateFile import debugPkg::*; #(
	parameter int REG_BITS = $clog2(`DEBUG_REG_COUNT)
) (
	input  logic                         CLK,
	input  logic                         arstN,
	input  logic                         coreRegWrite,
	input  logic [REG_BITS-1:0]          coreRegIndex,
	input  logic [`DEBUG_DATA_WIDTH-1:0] coreRegData,
	input  logic                         corePcLoad,
	input  logic [`DEBUG_DATA_WIDTH-1:0] corePcData,
	input  logic                         coreCcWrite,
	input  ccSelT                        coreCcSel,
	input  logic [`DEBUG_DATA_WIDTH-1:0] coreCcData,
	input  regSeqT                       regSeq,
	input  logic [REG_BITS-1:0]          regIndex,
	input  ccSelT                        ccSel,
	output logic [`DEBUG_DATA_WIDTH-1:0] regB,
	output logic [`DEBUG_DATA_WIDTH-1:0] ccWord,
	output logic [`DEBUG_DATA_WIDTH-1:0] pc
);

	logic [`DEBUG_DATA_WIDTH-1:0] regs [`DEBUG_REG_COUNT];
	logic [`DEBUG_DATA_WIDTH-1:0] ccRegs [4]; // run, intr, save1, save2

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `DEBUG_REG_COUNT; i++)
				regs[i] <= '0;
			for (int i = 0; i < 4; i++)
				ccRegs[i] <= '0;
			pc <= '0;
		end else begin
			if (coreRegWrite)
				regs[coreRegIndex] <= coreRegData;
			if (coreCcWrite)
				ccRegs[coreCcSel] <= coreCcData;
			if (corePcLoad)
				pc <= corePcData;
		end
	end

	// b port only drives when asked
	assign regB   = (regSeq == regSeqReadB) ? regs[regIndex] : '0;
	assign ccWord = ccRegs[ccSel];

endmodule

`default_nettype wire

// ==== source/debugMemory.sv ====
`default_nettype none
`include "debugPort_defines.svh"

module debugMemory (
	input  logic                         CLK,
	input  logic                         memRead,
	input  logic                         memWrite,
	input  logic [`DEBUG_ADDR_WIDTH-1:0] memAddr,
	input  logic [`DEBUG_DATA_WIDTH-1:0] memWData,
	output logic [`DEBUG_DATA_WIDTH-1:0] memRData
);

	logic [`DEBUG_DATA_WIDTH-1:0] mem [`DEBUG_MEM_DEPTH];

	always_ff @(posedge CLK) begin
		if (memWrite)
			mem[memAddr] <= memWData;
		if (memRead)
			memRData <= mem[memAddr]; // valid the cycle after the read
	end

endmodule

`default_nettype wire

// ==== source/debugPort.sv ====
`default_nettype none
`include "debugPort_defines.svh"

module debugPort import debugPkg::*; (
	input  logic                               CLK,
	input  logic                               arstN,
	input  logic                               debugStrobe,
	input  logic [4:0]                         debugOp,
	input  logic [2:0]                         debugArg,
	input  logic [`DEBUG_DATA_WIDTH-1:0]       debugDin,
	input  logic                               debugAddrLoad,
	output logic                               debugBusy,
	output logic                               debugDone,
	output logic [`DEBUG_DATA_WIDTH-1:0]       debugDout,
	output logic [`DEBUG_DATA_WIDTH-1:0]       debugInstr,
	input  logic                               coreRegWrite,
	input  logic [$clog2(`DEBUG_REG_COUNT)-1:0] coreRegIndex,
	input  logic [`DEBUG_DATA_WIDTH-1:0]       coreRegData,
	input  logic                               corePcLoad,
	input  logic [`DEBUG_DATA_WIDTH-1:0]       corePcData,
	input  logic                               coreCcWrite,
	input  ccSelT                              coreCcSel,
	input  logic [`DEBUG_DATA_WIDTH-1:0]       coreCcData
);

	debugOpT    op;
	logic       autoInc;
	logic [2:0] arg;
	logic       memRead;
	logic       memWrite;
	logic       execute;

	dataSelT    dataSel;
	busSeqT     busSeq;
	regSeqT     regSeq;
	ccSelT      ccSel;
	addrBusSelT addrBusSel;
	logic       ldData;
	logic       ldArg;
	logic       addrInc;

	logic [`DEBUG_ADDR_WIDTH-1:0]        memAddr;
	logic [`DEBUG_DATA_WIDTH-1:0]        memWData;
	logic [`DEBUG_DATA_WIDTH-1:0]        memRData;
	logic [$clog2(`DEBUG_REG_COUNT)-1:0] regIndex;
	logic [`DEBUG_DATA_WIDTH-1:0]        regB;
	logic [`DEBUG_DATA_WIDTH-1:0]        ccWord;
	logic [`DEBUG_DATA_WIDTH-1:0]        pc;

	debugSequencer i_debugSequencer (
		.CLK(CLK), .arstN(arstN),
		.debugStrobe(debugStrobe), .debugOp(debugOp), .debugArg(debugArg),
		.busSeq(busSeq),
		.op(op), .autoInc(autoInc), .arg(arg),
		.memRead(memRead), .memWrite(memWrite), .execute(execute),
		.debugBusy(debugBusy), .debugDone(debugDone)
	);

	debugDecoder i_debugDecoder (
		.op(op), .autoInc(autoInc), .arg(arg),
		.dataSel(dataSel), .busSeq(busSeq), .regSeq(regSeq), .ccSel(ccSel),
		.addrBusSel(addrBusSel),
		.ldData(ldData), .ldArg(ldArg), .addrInc(addrInc)
	);

	debugDatapath i_debugDatapath (
		.CLK(CLK), .arstN(arstN),
		.execute(execute), .debugAddrLoad(debugAddrLoad), .debugBusy(debugBusy),
		.debugDin(debugDin),
		.dataSel(dataSel), .ldData(ldData), .ldArg(ldArg), .addrInc(addrInc),
		.addrBusSel(addrBusSel),
		.regB(regB), .ccWord(ccWord), .pc(pc), .memRData(memRData),
		.memAddr(memAddr), .memWData(memWData), .regIndex(regIndex),
		.debugDout(debugDout), .debugInstr(debugInstr)
	);

	coreStateFile i_coreStateFile (
		.CLK(CLK), .arstN(arstN),
		.coreRegWrite(coreRegWrite), .coreRegIndex(coreRegIndex),
		.coreRegData(coreRegData),
		.corePcLoad(corePcLoad), .corePcData(corePcData),
		.coreCcWrite(coreCcWrite), .coreCcSel(coreCcSel), .coreCcData(coreCcData),
		.regSeq(regSeq), .regIndex(regIndex), .ccSel(ccSel),
		.regB(regB), .ccWord(ccWord), .pc(pc)
	);

	debugMemory i_debugMemory (
		.CLK(CLK),
		.memRead(memRead), .memWrite(memWrite),
		.memAddr(memAddr), .memWData(memWData), .memRData(memRData)
	);

endmodule

`default_nettype wire

// ==== sim/clockGen.sv ====
`default_nettype none

module clockGen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 8
) (
	output logic CLK,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	initial begin
		arstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		arstN = 1'b1; // release away from the active edge
	end

endmodule

`default_nettype wire

// ==== sim/debugPortTb.sv ====
`default_nettype none
`include "debugPort_defines.svh"

module debugPortTb import debugPkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DW = `DEBUG_DATA_WIDTH;
	localparam int AW = `DEBUG_ADDR_WIDTH;
	localparam int CMD_BUDGET = 600;
	localparam int CYCLES_PER_CMD = 5; // setup, issue, read wait, done, spare
	localparam int TIMEOUT_CYCLES = CMD_BUDGET * CYCLES_PER_CMD;

	typedef struct packed {
		logic [DW-1:0] dout;
		logic [DW-1:0] instr;
		logic [AW-1:0] addr;
	} expectT;

	logic          CLK;
	logic          arstN;
	logic          debugStrobe;
	logic [4:0]    debugOp;
	logic [2:0]    debugArg;
	logic [DW-1:0] debugDin;
	logic          debugAddrLoad;
	logic          debugBusy;
	logic          debugDone;
	logic [DW-1:0] debugDout;
	logic [DW-1:0] debugInstr;
	logic          coreRegWrite;
	logic [2:0]    coreRegIndex;
	logic [DW-1:0] coreRegData;
	logic          corePcLoad;
	logic [DW-1:0] corePcData;
	logic          coreCcWrite;
	ccSelT         coreCcSel;
	logic [DW-1:0] coreCcData;

	// models of the halted core and the port
	logic [DW-1:0] memModel [`DEBUG_MEM_DEPTH];
	logic [DW-1:0] regModel [`DEBUG_REG_COUNT];
	logic [DW-1:0] ccModel [4];
	logic [DW-1:0] pcModel;
	logic [DW-1:0] doutModel;
	logic [DW-1:0] instrModel;
	logic [AW-1:0] addrModel;

	expectT expQ[$];
	string  nameQ[$];
	int     cmdCount;
	int     doneCount;
	int     cycleCount;
	integer seed;

	clockGen #(.PERIOD_NS(40), .RESET_CYCLES(8)) i_clockGen (.CLK(CLK), .arstN(arstN));

	debugPort i_debugPort (.*);

	task automatic reportFailure(input string msg);
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1);
	endtask

	task automatic checkValue(input string name, input logic [DW-1:0] exp,
			input logic [DW-1:0] act);
		if (act !== exp)
			reportFailure($sformatf("error %s expected %h actual %h", name, exp, act));
	endtask

	function automatic logic [4:0] makeOp(input debugOpT cmd, input logic inc, input logic rsv);
		return {rsv, cmd, inc};
	endfunction

	// expected outputs and address after one command
	function automatic expectT refModel(input logic [4:0] opc, input logic [2:0] a);
		expectT e;
		e.dout  = doutModel;
		e.instr = instrModel;
		e.addr  = addrModel;
		case (opc[3:1])
			opRdReg: e.dout = regModel[addrModel[2:0]];
			opRdCc:  e.dout = ccModel[a[1:0]];
			opRdPc:  e.dout = pcModel;
			opRdInstruction: begin
				e.dout  = memModel[pcModel[AW-1:0]];
				e.instr = memModel[pcModel[AW-1:0]];
			end
			opRdMem: e.dout = memModel[addrModel];
			default: ;
		endcase
		if (opc[0] && (opc[3:1] == opRdReg || opc[3:1] == opRdMem || opc[3:1] == opWrMem))
			e.addr = addrModel + 1'b1; // only reg and memory commands step
		return e;
	endfunction

	task automatic runCommand(input string name, input logic [4:0] opc, input logic [2:0] a,
			input logic [DW-1:0] din, input bit intrude = 1'b0);
		expectT e;
		e = refModel(opc, a);
		expQ.push_back(e);
		nameQ.push_back(name);
		if (opc[3:1] == opWrMem)
			memModel[addrModel] = din;
		addrModel  = e.addr;
		doutModel  = e.dout;
		instrModel = e.instr;
		cmdCount++;
		@(posedge CLK);
		debugStrobe <= 1'b1;
		debugOp     <= opc;
		debugArg    <= a;
		debugDin    <= din;
		@(posedge CLK); // E0
		debugStrobe <= intrude;
		if (intrude) begin
			debugOp       <= makeOp(opWrMem, 1'b1, 1'b0); // must be dropped
			debugDin      <= 16'hdead;
			debugAddrLoad <= 1'b1;
		end
		@(negedge CLK);
		checkValue({name, " busy"}, 16'd1, 16'(debugBusy));
		if (intrude) begin
			@(posedge CLK);
			debugStrobe   <= 1'b0;
			debugAddrLoad <= 1'b0;
			@(negedge CLK);
		end
		while (debugDone !== 1'b1)
			@(negedge CLK);
	endtask

	task automatic loadAddress(input logic [AW-1:0] a);
		@(posedge CLK);
		debugAddrLoad <= 1'b1;
		debugDin      <= {{(DW-AW){1'b0}}, a};
		@(posedge CLK);
		debugAddrLoad <= 1'b0;
		addrModel = a;
	endtask

	task automatic writeCoreReg(input logic [2:0] idx, input logic [DW-1:0] data);
		@(posedge CLK);
		coreRegWrite <= 1'b1;
		coreRegIndex <= idx;
		coreRegData  <= data;
		@(posedge CLK);
		coreRegWrite <= 1'b0;
		regModel[idx] = data;
	endtask

	task automatic writeCc(input ccSelT sel, input logic [DW-1:0] data);
		@(posedge CLK);
		coreCcWrite <= 1'b1;
		coreCcSel   <= sel;
		coreCcData  <= data;
		@(posedge CLK);
		coreCcWrite <= 1'b0;
		ccModel[sel] = data;
	endtask

	task automatic loadPc(input logic [DW-1:0] data);
		@(posedge CLK);
		corePcLoad <= 1'b1;
		corePcData <= data;
		@(posedge CLK);
		corePcLoad <= 1'b0;
		pcModel = data;
	endtask

	// checks every done pulse against the oldest expectation
	initial begin
		expectT e;
		string  name;
		forever begin
			@(negedge CLK);
			if (debugDone === 1'b1) begin
				if (expQ.size() == 0) begin
					reportFailure("debugDone pulsed with no command outstanding");
				end else begin
					e    = expQ.pop_front();
					name = nameQ.pop_front();
					doneCount++;
					checkValue({name, " busy at done"}, 16'd0, 16'(debugBusy));
					checkValue({name, " dout"}, e.dout, debugDout);
					checkValue({name, " instr"}, e.instr, debugInstr);
				end
			end
		end
	end

	initial begin
		cycleCount = 0;
		forever begin
			@(posedge CLK);
			cycleCount++;
			if (cycleCount >= TIMEOUT_CYCLES)
				reportFailure($sformatf("simulation timed out after %0d cycles", cycleCount));
		end
	end

	initial begin
		logic [DW-1:0] word;
		debugStrobe   = 1'b0;
		debugOp       = '0;
		debugArg      = '0;
		debugDin      = '0;
		debugAddrLoad = 1'b0;
		coreRegWrite  = 1'b0;
		coreRegIndex  = '0;
		coreRegData   = '0;
		corePcLoad    = 1'b0;
		corePcData    = '0;
		coreCcWrite   = 1'b0;
		coreCcSel     = ccRun;
		coreCcData    = '0;
		seed       = 32'h3fb0201e;
		cmdCount   = 0;
		doneCount  = 0;
		pcModel    = '0;
		doutModel  = '0;
		instrModel = '0;
		addrModel  = '0;
		for (int i = 0; i < `DEBUG_REG_COUNT; i++)
			regModel[i] = '0;
		for (int i = 0; i < 4; i++)
			ccModel[i] = '0;

		@(posedge arstN);
		@(negedge CLK);
		checkValue("reset busy", 16'd0, 16'(debugBusy));
		checkValue("reset done", 16'd0, 16'(debugDone));
		checkValue("reset dout", 16'd0, debugDout);
		runCommand("reset write zero", makeOp(opWrMem, 1'b0, 1'b0), 3'd0, 16'h0000);
		runCommand("reset read zero", makeOp(opRdMem, 1'b0, 1'b0), 3'd0, 16'hffff);

		// burst crosses 255 to 0
		loadAddress(8'd224);
		for (int i = 0; i < 64; i++)
			runCommand("burst write", makeOp(opWrMem, 1'b1, 1'b0), 3'd0, 16'($random(seed)));
		loadAddress(8'd224);
		for (int i = 0; i < 64; i++)
			runCommand("burst read", makeOp(opRdMem, 1'b1, 1'b1), 3'd0, '0);

		for (int i = 0; i < 8; i++)
			writeCoreReg(3'(i), 16'($random(seed)));
		loadAddress(8'd5);
		for (int i = 0; i < 8; i++)
			runCommand("register read", makeOp(opRdReg, 1'b1, 1'b0), 3'd0, '0);

		for (int i = 0; i < 4; i++)
			writeCc(ccSelT'(2'(i)), 16'($random(seed)));
		loadAddress(8'd10);
		for (int i = 0; i < 4; i++)
			runCommand("cc read", makeOp(opRdCc, 1'b1, 1'b0), 3'(i), '0);
		runCommand("cc address kept", makeOp(opRdMem, 1'b0, 1'b0), 3'd0, '0);

		for (int k = 0; k < 2; k++) begin
			word = 16'($random(seed));
			loadAddress(word[AW-1:0]);
			runCommand("instruction store", makeOp(opWrMem, 1'b0, 1'b0), 3'd0,
				16'($random(seed)));
			loadPc(word);
			runCommand("pc read", makeOp(opRdPc, 1'b0, 1'b0), 3'd0, '0);
			runCommand("instruction read", makeOp(opRdInstruction, 1'b0, 1'b0), 3'd0, '0);
		end

		loadAddress(8'd20);
		runCommand("none keeps address", makeOp(opNone, 1'b1, 1'b0), 3'd0, 16'($random(seed)));
		runCommand("undefined keeps address", 5'b01111, 3'd0, 16'($random(seed))); // code 7
		runCommand("address after none", makeOp(opRdMem, 1'b0, 1'b0), 3'd0, '0);
		runCommand("read while busy", makeOp(opRdMem, 1'b0, 1'b0), 3'd0, '0, 1'b1);
		runCommand("address after busy", makeOp(opRdMem, 1'b0, 1'b0), 3'd0, '0);
		runCommand("write no increment", makeOp(opWrMem, 1'b0, 1'b0), 3'd0, 16'($random(seed)));
		runCommand("write readback", makeOp(opRdMem, 1'b0, 1'b0), 3'd0, '0);

		repeat (4) @(negedge CLK);
		if (doneCount == cmdCount) begin
			$display("All tests passed!");
			$finish;
		end else begin
			reportFailure($sformatf("error done count expected %0d actual %0d",
				cmdCount, doneCount));
		end
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+source
source/debugPkg.sv
source/debugDecoder.sv
source/debugSequencer.sv
source/debugDatapath.sv
source/coreStateFile.sv
source/debugMemory.sv
source/debugPort.sv
sim/clockGen.sv
sim/debugPortTb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module debugPortTb \
	-Mdir obj_dir -o simv \
	&& ./obj_dir/simv > sim.log 2>&1 \
	|| echo "Test failures found" >> sim.log
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
